/* Bender.yml */
package:
  name: bpf_filter

sources:
  # packages first, then leaf modules up to the top level
  - files:
      - logic/bpf_isa_pkg.sv
      - logic/bpf_core_pkg.sv
      - logic/sdpram.sv
      - logic/inst_mem.sv
      - logic/bpf_fetch.sv
      - logic/bpf_exec.sv
      - logic/bpf_filter_top.sv

  # simulation only
  - target: test
    files:
      - testbench/bpf_filter_checker.sv
      - testbench/bpf_filter_tb.sv

/* filelist.f */
logic/bpf_isa_pkg.sv
logic/bpf_core_pkg.sv
logic/sdpram.sv
logic/inst_mem.sv
logic/bpf_fetch.sv
logic/bpf_exec.sv
logic/bpf_filter_top.sv
testbench/bpf_filter_checker.sv
testbench/bpf_filter_tb.sv

/* logic/bpf_core_pkg.sv */
package bpf_core_pkg;

    typedef logic [31:0] word_t;  // accumulator, index and verdict width

    parameter int pc_width_def  = 10;  // 1024 program words
    parameter int pkt_width_def = 11;  // 2048 packet bytes

    // pc as carried between stages, a narrower pc_width sits in the low bits
    typedef logic [pc_width_def-1:0] pc_t;

    // fetch -> inst_mem read request
    typedef struct packed {
        logic valid;  // one cycle, doubles as RAM read enable
        pc_t  pc;
    } fetch_req_t;

    // fetch -> exec, instruction paired with its address
    typedef struct packed {
        logic                valid;
        pc_t                 pc;
        bpf_isa_pkg::instr_t instr;
    } exec_in_t;

    // exec -> fetch, end of one instruction
    typedef struct packed {
        logic valid;    // one cycle per executed instruction
        logic halt;     // return taken, stop fetching
        pc_t  next_pc;
    } branch_t;

endpackage

/* logic/bpf_exec.sv */
module bpf_exec #(
    parameter int pkt_width = bpf_core_pkg::pkt_width_def
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  bpf_core_pkg::exec_in_t from_fetch,
    output logic [pkt_width-1:0]   pkt_rd_addr,
    output logic                   pkt_rd_en,
    input  logic [7:0]             pkt_byte,
    output bpf_core_pkg::branch_t  branch,
    output logic                   done,
    output bpf_core_pkg::word_t    verdict
);
    import bpf_isa_pkg::*;
    import bpf_core_pkg::*;

    typedef enum logic [1:0] {
        st_idle,     // waiting for an instruction
        st_byte_hi,  // high byte back, low byte read issued
        st_byte_lo,  // last byte back, write A or X
        st_finish    // branch word out
    } state_t;

    state_t               state_q;
    word_t                a_q;
    word_t                x_q;
    word_t                verdict_q;
    logic                 halt_q;
    pc_t                  next_pc_q;
    instr_t               ins_q;   // load being finished
    logic [7:0]           hi_q;    // first byte of a half-word, big-endian
    logic [pkt_width-1:0] addr_q;  // second byte address

    instr_t ins;
    word_t  a_in;
    word_t  x_in;
    word_t  base;
    logic   is_load;
    logic   taken;
    pc_t    pc_plus1;
    pc_t    next_pc;

    assign ins = from_fetch.instr;

    // jumps only go forward, so pc 0 marks a fresh run with A and X cleared
    assign a_in = (from_fetch.pc == '0) ? '0 : a_q;
    assign x_in = (from_fetch.pc == '0) ? '0 : x_q;

    assign is_load = ((ins.op.cls == cls_ld) && (ins.op.mode == md_abs || ins.op.mode == md_ind))
                  || ((ins.op.cls == cls_ldx) && (ins.op.mode == md_msh));

    assign base = (ins.op.mode == md_ind) ? x_in + ins.k : ins.k;  // abs and msh use k

    always_comb begin
        case (ins.op.mode)
            jt_jeq:  taken = (a_in == ins.k);
            jt_jgt:  taken = (a_in > ins.k);           // unsigned compare
            jt_jset: taken = ((a_in & ins.k) != '0);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus1 = from_fetch.pc + pc_t'(1);
    assign next_pc  = (ins.op.cls == cls_jmp) ? pc_plus1 + pc_t'(taken ? ins.jt : ins.jf)
                                              : pc_plus1;

    // first byte straight from the incoming word, later bytes from addr_q
    assign pkt_rd_en   = (state_q == st_idle && from_fetch.valid && is_load)
                      || (state_q == st_byte_hi);
    assign pkt_rd_addr = (state_q == st_byte_hi) ? addr_q : base[pkt_width-1:0];  // wraps

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= st_idle;
            a_q       <= '0;
            x_q       <= '0;
            verdict_q <= '0;
            halt_q    <= 1'b0;
            next_pc_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (from_fetch.valid) begin
                        a_q       <= a_in;
                        x_q       <= x_in;
                        halt_q    <= (ins.op.cls == cls_ret);
                        next_pc_q <= next_pc;
                        if (ins.op.cls == cls_ret) begin
                            verdict_q <= (ins.op.size == ret_a) ? a_in : ins.k;
                        end
                        if (!is_load) begin
                            state_q <= st_finish;   // jump, return or unsupported op
                        end else if (ins.op.size == sz_h) begin
                            state_q <= st_byte_hi;
                        end else begin
                            state_q <= st_byte_lo;  // byte load and msh
                        end
                    end
                end
                st_byte_hi: state_q <= st_byte_lo;
                st_byte_lo: begin
                    if (ins_q.op.cls == cls_ldx) begin
                        x_q <= {26'h0, pkt_byte[3:0], 2'b00};  // header length in bytes
                    end else if (ins_q.op.size == sz_h) begin
                        a_q <= {16'h0, hi_q, pkt_byte};
                    end else begin
                        a_q <= {24'h0, pkt_byte};
                    end
                    state_q <= st_finish;
                end
                st_finish: state_q <= st_idle;
                default:   state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && from_fetch.valid) begin
            ins_q  <= ins;
            addr_q <= base[pkt_width-1:0] + pkt_width'(1);
        end
        if (state_q == st_byte_hi) begin
            hi_q <= pkt_byte;
        end
    end

    assign branch  = '{valid: state_q == st_finish, halt: halt_q, next_pc: next_pc_q};
    assign done    = (state_q == st_finish) && halt_q;  // one cycle per return
    assign verdict = verdict_q;                          // held until the next return

endmodule

/* logic/bpf_fetch.sv */
module bpf_fetch #(
    parameter int pc_width = bpf_core_pkg::pc_width_def  // at most pc_width_def
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  bpf_core_pkg::branch_t    branch,
    output bpf_core_pkg::fetch_req_t req,
    input  bpf_isa_pkg::instr_t      instr,
    output bpf_core_pkg::exec_in_t   to_exec,
    output logic                     busy
);
    import bpf_core_pkg::*;

    logic                busy_q;
    logic                req_valid_q;  // read issued this cycle
    logic                rsp_valid_q;  // RAM word valid this cycle
    logic [pc_width-1:0] pc_q;         // address of the instruction in flight
    logic                launch;
    logic                advance;

    assign launch  = start && !busy_q;              // start while running is dropped
    assign advance = branch.valid && !branch.halt;  // exec finished, go on

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
            pc_q        <= '0;
        end else begin
            req_valid_q <= launch || advance;  // next read one cycle after branch
            rsp_valid_q <= req_valid_q;        // data returns one cycle after the read
            if (launch) begin
                busy_q <= 1'b1;
                pc_q   <= '0;                  // programs always enter at 0
            end else if (advance) begin
                pc_q <= branch.next_pc[pc_width-1:0];
            end
            if (branch.valid && branch.halt) begin
                busy_q <= 1'b0;                // low from the cycle after done
            end
        end
    end

    assign req = '{valid: req_valid_q, pc: pc_t'(pc_q)};

    // pc_q still names the word now on the RAM output
    assign to_exec = '{valid: rsp_valid_q, pc: pc_t'(pc_q), instr: instr};

    assign busy = busy_q;

endmodule

/* logic/bpf_filter_top.sv */
module bpf_filter_top #(
    parameter int pc_width  = bpf_core_pkg::pc_width_def,
    parameter int pkt_width = bpf_core_pkg::pkt_width_def
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 prog_wr_en,
    input  logic [pc_width-1:0]  prog_addr,
    input  bpf_isa_pkg::instr_t  prog_data,
    input  logic                 pkt_wr_en,
    input  logic [pkt_width-1:0] pkt_addr,
    input  logic [7:0]           pkt_byte,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output bpf_core_pkg::word_t  verdict
);
    import bpf_isa_pkg::*;
    import bpf_core_pkg::*;

    fetch_req_t           fetch_req;
    exec_in_t             exec_in;
    branch_t              exec_branch;
    instr_t               mem_instr;
    logic                 prog_wr_ok;
    logic                 pkt_wr_ok;
    logic                 pkt_rd_en;
    logic                 pkt_en;
    logic [pkt_width-1:0] pkt_rd_addr;
    logic [7:0]           pkt_rd_byte;

    assign prog_wr_ok = prog_wr_en && !busy;  // host writes dropped while running
    assign pkt_wr_ok  = pkt_wr_en && !busy;
    assign pkt_en     = pkt_wr_ok | pkt_rd_en;

    inst_mem #(
        .addr_width (pc_width)
    ) imem0 (
        .clk     (clk),
        .wr_en   (prog_wr_ok),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_en   (fetch_req.valid),
        .rd_addr (fetch_req.pc[pc_width-1:0]),
        .rd_data (mem_instr)
    );

    sdpram #(
        .addr_width (pkt_width),
        .word_type  (logic [7:0])
    ) pmem0 (
        .clk     (clk),
        .en      (pkt_en),
        .wr_en   (pkt_wr_ok),
        .wr_addr (pkt_addr),
        .wr_data (pkt_byte),
        .rd_addr (pkt_rd_addr),
        .rd_data (pkt_rd_byte)
    );

    bpf_fetch #(
        .pc_width (pc_width)
    ) fetch0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .branch  (exec_branch),
        .req     (fetch_req),
        .instr   (mem_instr),
        .to_exec (exec_in),
        .busy    (busy)
    );

    bpf_exec #(
        .pkt_width (pkt_width)
    ) exec0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .from_fetch  (exec_in),
        .pkt_rd_addr (pkt_rd_addr),
        .pkt_rd_en   (pkt_rd_en),
        .pkt_byte    (pkt_rd_byte),
        .branch      (exec_branch),
        .done        (done),
        .verdict     (verdict)
    );

endmodule

/* logic/bpf_isa_pkg.sv */
package bpf_isa_pkg;

    typedef logic [2:0] mode_t;  // opcode bits 7:5, jump test for jmp class
    typedef logic [1:0] size_t;  // opcode bits 4:3, return source for ret class
    typedef logic [2:0] cls_t;   // opcode bits 2:0

    typedef struct packed {
        mode_t mode;
        size_t size;
        cls_t  cls;
    } opcode_t;

    // 64-bit program word as stored in the instruction memory
    typedef struct packed {
        logic [7:0]  pad;   // unused, kept for 64-bit alignment
        opcode_t     op;
        logic [7:0]  jt;    // skip count when the test holds
        logic [7:0]  jf;    // skip count when it fails
        logic [31:0] k;     // immediate, offset or return value
    } instr_t;

    // instruction classes
    parameter cls_t cls_ld  = 3'b000;
    parameter cls_t cls_ldx = 3'b001;
    parameter cls_t cls_jmp = 3'b101;
    parameter cls_t cls_ret = 3'b110;

    // load sizes, word loads are not supported
    parameter size_t sz_h = 2'b01;
    parameter size_t sz_b = 2'b10;

    // load addressing modes
    parameter mode_t md_abs = 3'b001;  // [k]
    parameter mode_t md_ind = 3'b010;  // [x + k]
    parameter mode_t md_msh = 3'b101;  // x = 4 * ([k] & 0xf)

    // jump tests, all compare A against k
    parameter mode_t jt_jeq  = 3'b001;
    parameter mode_t jt_jgt  = 3'b010;
    parameter mode_t jt_jset = 3'b100;

    // return source
    parameter size_t ret_k = 2'b00;
    parameter size_t ret_a = 2'b10;

endpackage

/* logic/inst_mem.sv */
module inst_mem #(
    parameter int addr_width = bpf_core_pkg::pc_width_def
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  bpf_isa_pkg::instr_t   wr_data,
    input  logic                  rd_en,
    input  logic [addr_width-1:0] rd_addr,
    output bpf_isa_pkg::instr_t   rd_data
);
    import bpf_isa_pkg::*;

    logic ram_en;

    assign ram_en = rd_en | wr_en;  // output word holds between fetches

    sdpram #(
        .addr_width (addr_width),
        .word_type  (instr_t)
    ) ram0 (
        .clk     (clk),
        .en      (ram_en),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* logic/sdpram.sv */
module sdpram #(
    parameter int  addr_width = 10,
    parameter type word_type  = logic [7:0]
) (
    input  logic                  clk,
    input  logic                  en,       // clock enable for both ports
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  word_type              wr_data,
    input  logic [addr_width-1:0] rd_addr,
    output word_type              rd_data
);

    word_type mem [2**addr_width];  // no reset so it infers block RAM

    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
            rd_data <= mem[rd_addr];  // registered read, one cycle latency
        end
    end

endmodule

/* testbench/bpf_filter_checker.sv */
module bpf_filter_checker (
    input logic clk,
    input logic arst_n,
    input logic done,
    input logic busy,
    input logic exec_valid   // fetch -> exec word valid
);

    // a return ends the run in exactly one cycle
    done_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    ) else $error("done stayed high for more than one cycle");

    // a done can only close a run that was already going
    done_after_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> $past(busy)
    ) else $error("done without busy in the previous cycle");

    // fetch hands exec nothing while idle
    exec_inside_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        exec_valid |-> busy
    ) else $error("instruction reached exec while not busy");

    // no second done for the same run
    done_ends_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !busy
    ) else $error("busy still high after done");

endmodule

/* testbench/bpf_filter_tb.sv */
module bpf_filter_tb;
    import bpf_isa_pkg::*;
    import bpf_core_pkg::*;

    localparam int pc_width     = pc_width_def;
    localparam int pkt_width    = pkt_width_def;
    localparam int frame_len    = 64;   // long enough for ihl up to 7
    localparam int prog_len     = 16;
    localparam int done_timeout = 200;  // cycles from start to done

    // one row of the packet table
    typedef struct packed {
        logic [15:0] ethertype;
        logic [7:0]  proto;
        logic [15:0] frag;       // flags and fragment offset
        logic [3:0]  ihl;        // ip header length in words
        logic [15:0] sport;
        logic [15:0] dport;
    } pkt_case_t;

    logic                 clk;
    logic                 arst_n;
    logic                 prog_wr_en;
    logic [pc_width-1:0]  prog_addr;
    instr_t               prog_data;
    logic                 pkt_wr_en;
    logic [pkt_width-1:0] pkt_addr;
    logic [7:0]           pkt_byte;
    logic                 start;
    logic                 busy;
    logic                 done;
    word_t                verdict;

    instr_t      prog_words [prog_len];
    pkt_case_t   cases [$];
    int          checks;
    int          errors;
    int          done_count;       // done pulses seen since reset
    int          starts;           // start pulses given since reset
    word_t       got;

    bpf_filter_top #(
        .pc_width  (pc_width),
        .pkt_width (pkt_width)
    ) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .prog_wr_en (prog_wr_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pkt_wr_en  (pkt_wr_en),
        .pkt_addr   (pkt_addr),
        .pkt_byte   (pkt_byte),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .verdict    (verdict)
    );

    bind bpf_filter_top bpf_filter_checker chk0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .done       (done),
        .busy       (busy),
        .exec_valid (exec_in.valid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 unit period

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;  // counts every pulse
        end
    end

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic instr_t make_instr(input mode_t m, input size_t s, input cls_t c,
                                          input logic [7:0] t, input logic [7:0] f,
                                          input word_t k);
        instr_t ins;
        ins         = '0;
        ins.op.mode = m;
        ins.op.size = s;
        ins.op.cls  = c;
        ins.jt      = t;
        ins.jf      = f;
        ins.k       = k;
        return ins;
    endfunction

    // accepts ipv4 tcp non-fragments with ports 100 and 200 either way round
    task automatic build_program();
        prog_words[0]  = make_instr(md_abs, sz_h, cls_ld, 0, 0, 12);           // ethertype
        prog_words[1]  = make_instr(jt_jeq, 2'b00, cls_jmp, 0, 13, 32'h0800);
        prog_words[2]  = make_instr(md_abs, sz_b, cls_ld, 0, 0, 23);           // protocol
        prog_words[3]  = make_instr(jt_jeq, 2'b00, cls_jmp, 0, 11, 6);
        prog_words[4]  = make_instr(md_abs, sz_h, cls_ld, 0, 0, 20);           // flags and offset
        prog_words[5]  = make_instr(jt_jset, 2'b00, cls_jmp, 9, 0, 32'h1fff);
        prog_words[6]  = make_instr(md_msh, sz_b, cls_ldx, 0, 0, 14);          // x = ip hdr len
        prog_words[7]  = make_instr(md_ind, sz_h, cls_ld, 0, 0, 14);           // src port
        prog_words[8]  = make_instr(jt_jeq, 2'b00, cls_jmp, 0, 2, 100);
        prog_words[9]  = make_instr(md_ind, sz_h, cls_ld, 0, 0, 16);           // dst port
        prog_words[10] = make_instr(jt_jeq, 2'b00, cls_jmp, 3, 4, 200);
        prog_words[11] = make_instr(jt_jeq, 2'b00, cls_jmp, 0, 3, 200);        // swapped order
        prog_words[12] = make_instr(md_ind, sz_h, cls_ld, 0, 0, 16);
        prog_words[13] = make_instr(jt_jeq, 2'b00, cls_jmp, 0, 1, 100);
        prog_words[14] = make_instr(3'b000, ret_k, cls_ret, 0, 0, 65535);      // accept
        prog_words[15] = make_instr(3'b000, ret_k, cls_ret, 0, 0, 0);          // drop
    endtask

    task automatic write_instr(input int addr, input instr_t ins);
        @(negedge clk);
        prog_wr_en = 1'b1;
        prog_addr  = pc_width'(addr);
        prog_data  = ins;
        @(negedge clk);
        prog_wr_en = 1'b0;
    endtask

    task automatic add_case(input logic [15:0] et, input logic [7:0] pr, input logic [15:0] fr,
                            input logic [3:0] ihl, input logic [15:0] sp, input logic [15:0] dp);
        cases.push_back('{ethertype: et, proto: pr, frag: fr, ihl: ihl, sport: sp, dport: dp});
    endtask

    task automatic fill_table();
        add_case(16'h0800, 8'd6,  16'h0000, 4'd5, 16'd100, 16'd200);  // plain accept
        add_case(16'h0800, 8'd6,  16'h4000, 4'd6, 16'd200, 16'd100);  // df set with ip options
        add_case(16'h86dd, 8'd6,  16'h0000, 4'd5, 16'd100, 16'd200);  // ipv6 ethertype
        add_case(16'h0800, 8'd17, 16'h0000, 4'd5, 16'd100, 16'd200);  // udp
        add_case(16'h0800, 8'd6,  16'h2001, 4'd5, 16'd100, 16'd200);  // offset 1
        add_case(16'h0800, 8'd6,  16'h0000, 4'd5, 16'd100, 16'd100);
        add_case(16'h0800, 8'd6,  16'h0000, 4'd6, 16'd300, 16'd200);
        add_case(16'h0800, 8'd6,  16'h0000, 4'd5, 16'd200, 16'd300);
        add_case(16'h0800, 8'd6,  16'h2000, 4'd7, 16'd100, 16'd200);  // mf set on first frag
        add_case(16'h0806, 8'd1,  16'h0000, 4'd5, 16'd0,   16'd0);    // arp leaves A nonzero
    endtask

    function automatic word_t expected_verdict(input pkt_case_t c);
        logic ports_ok;
        logic ip_ok;
        ports_ok = (c.sport == 16'd100 && c.dport == 16'd200)
                || (c.sport == 16'd200 && c.dport == 16'd100);
        ip_ok    = (c.ethertype == 16'h0800) && (c.proto == 8'd6) && ((c.frag & 16'h1fff) == 0);
        if (ip_ok && ports_ok) begin
            return 32'd65535;
        end else begin
            return 32'd0;
        end
    endfunction

    task automatic load_frame(input pkt_case_t c);
        logic [7:0] frame [frame_len];
        int         hdr;
        for (int i = 0; i < frame_len; i++) begin
            frame[i] = 8'($urandom);  // random filler bytes
        end
        hdr        = 14 + 4 * c.ihl;  // l4 header behind the ip options
        frame[12]  = c.ethertype[15:8];
        frame[13]  = c.ethertype[7:0];
        frame[14]  = {4'h4, c.ihl};
        frame[20]  = c.frag[15:8];
        frame[21]  = c.frag[7:0];
        frame[23]  = c.proto;
        frame[hdr]     = c.sport[15:8];
        frame[hdr + 1] = c.sport[7:0];
        frame[hdr + 2] = c.dport[15:8];
        frame[hdr + 3] = c.dport[7:0];
        for (int i = 0; i < frame_len; i++) begin
            @(negedge clk);
            pkt_wr_en = 1'b1;
            pkt_addr  = pkt_width'(i);
            pkt_byte  = frame[i];
        end
        @(negedge clk);
        pkt_wr_en = 1'b0;
    endtask

    task automatic run_filter(output word_t result);
        int cycles;
        check_value("done pulses between runs", word_t'(done_count), word_t'(starts));
        @(negedge clk);
        start = 1'b1;
        starts++;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!done) begin
            if (cycles >= done_timeout) begin
                $display("timeout: no done within %0d cycles after start", done_timeout);
                $display("checks %0d, errors %0d, timeouts 1", checks, errors);
                $display("*** TEST FAILED ***");
                $finish;
            end
            @(negedge clk);
            cycles++;
        end
        result = verdict;  // sampled in the done cycle
        @(negedge clk);
        check_value("busy after done", word_t'(busy), 0);
        check_value("verdict held after done", verdict, result);
        check_value("done pulses per start", word_t'(done_count), word_t'(starts));
    endtask

    initial begin
        void'($urandom(32'ha7ee));
        checks     = 0;
        errors     = 0;
        starts     = 0;
        arst_n     = 1'b0;
        start      = 1'b0;
        prog_wr_en = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        pkt_wr_en  = 1'b0;
        pkt_addr   = '0;
        pkt_byte   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        build_program();
        for (int i = 0; i < prog_len; i++) begin
            write_instr(i, prog_words[i]);
        end
        fill_table();
        check_value("done before first start", word_t'(done_count), 0);
        check_value("busy before first start", word_t'(busy), 0);

        for (int i = 0; i < cases.size(); i++) begin
            load_frame(cases[i]);
            run_filter(got);
            check_value($sformatf("verdict of case %0d", i), got, expected_verdict(cases[i]));
        end

        // A still holds 0x0806 from the arp frame and must read as zero in a new run
        write_instr(0, make_instr(3'b000, ret_a, cls_ret, 0, 0, 32'hdead));
        run_filter(got);
        check_value("return A at pc 0", got, 0);

        $display("checks %0d, errors %0d, timeouts 0", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
